/* all.f */
logic/sl_pkg.sv
logic/obi_phase_monitor.sv
logic/req_attribute_fifo.sv
logic/exception_trigger_unit.sv
logic/core_event_tracker.sv
logic/support_logic.sv
dv/tb_support_logic.sv

/* dv/tb_support_logic.sv */
// outputs are checked at the falling edge against models and obi stimulus never exceeds four outstanding
`timescale 1ns/1ps
`default_nettype none

module tb_support_logic;

  localparam int CLK_PERIOD    = 40;
  localparam int APB_TIMEOUT   = 8;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int OBI_CYCLES    = 400;
  // exception causes for trigger retirements with only some of them programmed
  localparam logic [4:0] CAUSES [4] = '{5'd2, 5'd3, 5'd8, 5'd11};

  logic                   in_support_if;
  logic                   rst_n_i;
  sl_pkg::sl_retire_t     retire;
  sl_pkg::sl_ctrl_t       ctrl;
  sl_pkg::sl_obi_t        obi [2];
  logic                   fetch_enable;
  logic                   debug_req;
  logic                   integ [2];
  logic                   is_store;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [4:0]             paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  sl_pkg::sl_obi_status_t status [2];
  sl_pkg::sl_instr_attr_t instr_attr;
  sl_pkg::sl_data_attr_t  data_attr;
  logic                   etrig_hit;
  sl_pkg::sl_event_t      events;

  integer seed = 32'h6107_d0c8;

  // ----------------------------------------
  // model state
  // ----------------------------------------
  // index 0 is the instruction bus and 1 the data bus
  int unsigned mdl_cnt [2];
  logic        mdl_wait [2];
  logic        mdl_perr [2];
  // {is_store, integrity, gntpar_err} per accepted request
  logic [2:0]  instr_q [$];
  logic [2:0]  data_q [$];
  logic [31:0] sh_tdata1 [sl_pkg::NUM_TRIGGERS];
  logic [31:0] sh_tdata2 [sl_pkg::NUM_TRIGGERS];
  logic        ff_seen;
  logic        dbg_flag;
  logic        dret_pend;
  logic        rec_dbg;
  logic [1:0]  rec_cnt;
  logic        exc_act;
  logic        dgnt_q;
  logic        rae;

  always #(CLK_PERIOD / 2) in_support_if = ~in_support_if;

  support_logic u_support_logic (
    .in_support_if     (in_support_if),
    .rst_n_i           (rst_n_i),
    .retire_i          (retire),
    .ctrl_i            (ctrl),
    .instr_bus_i       (obi[0]),
    .data_bus_i        (obi[1]),
    .fetch_enable_i    (fetch_enable),
    .debug_req_i       (debug_req),
    .instr_integrity_i (integ[0]),
    .data_integrity_i  (integ[1]),
    .data_is_store_i   (is_store),
    .psel_i            (psel),
    .penable_i         (penable),
    .pwrite_i          (pwrite),
    .paddr_i           (paddr),
    .pwdata_i          (pwdata),
    .prdata_o          (prdata),
    .pready_o          (pready),
    .pslverr_o         (pslverr),
    .instr_status_o    (status[0]),
    .data_status_o     (status[1]),
    .instr_resp_attr_o (instr_attr),
    .data_resp_attr_o  (data_attr),
    .etrig_hit_o       (etrig_hit),
    .events_o          (events)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    abort_run($sformatf("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  function automatic int unsigned rnd(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // exception trigger rule applied to the host-side copy of the registers
  function automatic logic expect_hit(input sl_pkg::sl_retire_t r);
    logic hit;
    hit = 1'b0;
    for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
      if (r.valid && r.exception
          && sh_tdata1[t][sl_pkg::TRIG_TYPE_MSB:sl_pkg::TRIG_TYPE_LSB]
             == sl_pkg::TRIG_TYPE_ETRIGGER
          && sh_tdata2[t][r.exception_cause]
          && ((r.is_mmode && sh_tdata1[t][sl_pkg::ET_M_BIT])
              || (r.is_umode && sh_tdata1[t][sl_pkg::ET_U_BIT]))) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic reset_models();
    for (int b = 0; b < 2; b++) begin
      mdl_cnt[b]  = 0;
      mdl_wait[b] = 1'b0;
      mdl_perr[b] = 1'b0;
    end
    instr_q.delete();
    data_q.delete();
    for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
      sh_tdata1[t] = sl_pkg::TDATA1_DEFAULT;
      sh_tdata2[t] = '0;
    end
    {ff_seen, dbg_flag, dret_pend, rec_dbg, exc_act, dgnt_q, rae} = '0;
    rec_cnt = '0;
  endtask

  // ----------------------------------------
  // checkers
  // ----------------------------------------
  task automatic check_obi(input int b);
    sl_pkg::sl_obi_t bus;
    string           pfx;
    logic            exp_perr;
    logic            exp_rpc;
    logic [2:0]      exp_attr;
    logic [2:0]      act_attr;
    bus      = obi[b];
    pfx      = (b == 0) ? "instr" : "data";
    exp_perr = bus.req & ((bus.gnt == bus.gntpar) | mdl_perr[b]);
    exp_rpc  = bus.rvalid & (mdl_cnt[b] != 0);
    act_attr = (b == 0) ? {1'b0, instr_attr} : data_attr;
    exp_attr = '0;
    if (bus.rvalid) begin
      exp_attr = (b == 0) ? instr_q.pop_front() : data_q.pop_front();
    end
    assert (status[b].v_addr_ph_cnt == mdl_cnt[b])
      else report_mismatch({pfx, "_status_o.v_addr_ph_cnt"}, mdl_cnt[b],
                           status[b].v_addr_ph_cnt);
    assert (status[b].addr_ph_cont == (bus.req & mdl_wait[b]))
      else report_mismatch({pfx, "_status_o.addr_ph_cont"}, bus.req & mdl_wait[b],
                           status[b].addr_ph_cont);
    assert (status[b].resp_ph_cont == exp_rpc)
      else report_mismatch({pfx, "_status_o.resp_ph_cont"}, exp_rpc,
                           status[b].resp_ph_cont);
    assert (status[b].gntpar_err == exp_perr)
      else report_mismatch({pfx, "_status_o.gntpar_err"}, exp_perr, status[b].gntpar_err);
    assert (act_attr == exp_attr)
      else report_mismatch({pfx, "_resp_attr_o"}, exp_attr, act_attr);
    // record the request side for the matching response
    if (bus.req && bus.gnt) begin
      if (b == 0) begin
        instr_q.push_back({1'b0, integ[0], exp_perr});
      end else begin
        data_q.push_back({is_store, integ[1], exp_perr});
      end
      mdl_cnt[b]++;
    end
    if (bus.rvalid) begin
      mdl_cnt[b]--;
    end
    mdl_wait[b] = bus.req & ~bus.gnt;
    mdl_perr[b] = bus.req & ~bus.gnt & exp_perr;
  endtask

  task automatic check_events();
    logic exp_ff;
    logic exp_fdi;
    logic exp_hit;
    exp_ff  = fetch_enable & ~ff_seen;
    exp_fdi = retire.valid & retire.dbg_mode & ~dbg_flag;
    exp_hit = expect_hit(retire);
    assert (events.first_fetch == exp_ff)
      else report_mismatch("events_o.first_fetch", exp_ff, events.first_fetch);
    assert (events.first_debug_ins == exp_fdi)
      else report_mismatch("events_o.first_debug_ins", exp_fdi, events.first_debug_ins);
    assert (events.recorded_dbg_req == rec_dbg)
      else report_mismatch("events_o.recorded_dbg_req", rec_dbg, events.recorded_dbg_req);
    assert (events.req_after_exception == rae)
      else report_mismatch("events_o.req_after_exception", rae, events.req_after_exception);
    assert (etrig_hit == exp_hit)
      else report_mismatch("etrig_hit_o", exp_hit, etrig_hit);
    ff_seen = ff_seen | fetch_enable;
    // debug flag rearms the cycle after an untrapped dret
    if (dret_pend) begin
      dbg_flag  = 1'b0;
      dret_pend = 1'b0;
    end else if (retire.valid) begin
      dbg_flag  = retire.dbg_mode;
      dret_pend = retire.is_dret & ~retire.trap;
    end
    // debug request record counts down on retirements
    if (retire.valid) begin
      if (debug_req) begin
        rec_dbg = 1'b1;
        rec_cnt = 2'd1;
      end else if (rec_cnt != 0) begin
        rec_cnt--;
      end else begin
        rec_dbg = 1'b0;
      end
    end else if (debug_req) begin
      rec_dbg = 1'b1;
      rec_cnt = 2'd2;
    end
    // data request after a trap is cleared by the next retirement
    if (ctrl.pc_set && ctrl.pc_is_trap) begin
      exc_act = 1'b1;
      rae     = rae | (obi[1].req & dgnt_q);
    end else if (retire.valid) begin
      exc_act = 1'b0;
      rae     = 1'b0;
    end else if (exc_act && dgnt_q && obi[1].req) begin
      rae = 1'b1;
    end
    dgnt_q = obi[1].gnt;
  endtask

  // compare at the falling edge while inputs and registered outputs are stable
  always @(negedge in_support_if) begin
    if (!rst_n_i) begin
      reset_models();
    end else begin
      check_obi(0);
      check_obi(1);
      check_events();
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  // one bus cycle where a waiting request is held until granted
  task automatic drive_obi(input int b, input logic en);
    logic hold;
    hold = mdl_wait[b];
    obi[b].req = hold | (en & (rnd(2) == 0));
    if (!hold) begin
      integ[b] = (rnd(2) == 1);
      if (b == 1) begin
        is_store = (rnd(2) == 1);
      end
    end
    obi[b].gnt    = obi[b].req && (mdl_cnt[b] < sl_pkg::OBI_MAX_OUTSTANDING)
                    && (!en || rnd(3) == 0);
    // occasional bad parity
    obi[b].gntpar = (rnd(6) == 0) ? obi[b].gnt : ~obi[b].gnt;
    obi[b].rvalid = (mdl_cnt[b] != 0) && (rnd(2) == 0);
  endtask

  task automatic apb_access(input logic wr, input logic [1:0] idx, input logic sel,
                            input logic [31:0] wdata);
    int          n;
    logic        done;
    logic [31:0] exp_rd;
    logic        exp_err;
    @(posedge in_support_if);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = {idx, sel, 2'(rnd(4))};
    pwdata  = wdata;
    @(posedge in_support_if);
    #2;
    penable = 1'b1;
    n       = 0;
    done    = 1'b0;
    exp_rd  = sel ? sh_tdata2[idx] : sh_tdata1[idx];
    exp_err = (int'(idx) >= sl_pkg::NUM_TRIGGERS);
    while (!done) begin
      @(negedge in_support_if);
      n++;
      if (pready) begin
        done = 1'b1;
        assert (n == 2) else report_mismatch("pready_o access cycles", 2, n);
        assert (pslverr == exp_err) else report_mismatch("pslverr_o", exp_err, pslverr);
        if (!wr) begin
          assert (prdata == exp_rd) else report_mismatch("prdata_o", exp_rd, prdata);
        end else if (!exp_err) begin
          if (sel) begin
            sh_tdata2[idx] = wdata;
          end else begin
            sh_tdata1[idx] = wdata;
          end
        end
      end else if (n >= APB_TIMEOUT) begin
        abort_run("apb transfer did not complete within the timeout");
      end
    end
    @(posedge in_support_if);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic retire_one(input logic dbg, input logic dret, input logic exc,
                            input logic [4:0] cause, input logic mmode, input logic dreq);
    @(posedge in_support_if);
    #2;
    retire                 = '0;
    retire.valid           = 1'b1;
    retire.dbg_mode        = dbg;
    retire.is_dret         = dret;
    retire.exception       = exc;
    retire.exception_cause = cause;
    retire.is_mmode        = mmode;
    retire.is_umode        = ~mmode;
    debug_req              = dreq;
    @(posedge in_support_if);
    #2;
    retire    = '0;
    debug_req = 1'b0;
  endtask

  initial begin
    int  n;
    logic done;
    in_support_if = 1'b0;
    rst_n_i       = 1'b0;
    retire        = '0;
    ctrl          = '0;
    obi[0]        = '0;
    obi[1]        = '0;
    fetch_enable  = 1'b0;
    debug_req     = 1'b0;
    integ[0]      = 1'b0;
    integ[1]      = 1'b0;
    is_store      = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    repeat (10) @(posedge in_support_if);
    #2;
    rst_n_i = 1'b1;
    repeat (2) @(posedge in_support_if);
    #2;
    fetch_enable = 1'b1;

    // trigger register defaults then writes then read back
    for (int i = 0; i < 8; i++) begin
      apb_access(1'b0, 2'(i / 2), i[0], '0);
    end
    apb_access(1'b1, 2'd0, 1'b0, 32'h5000_0200);
    apb_access(1'b1, 2'd0, 1'b1, 32'h0000_0808);
    apb_access(1'b1, 2'd1, 1'b0, 32'h5000_0040);
    apb_access(1'b1, 2'd1, 1'b1, 32'h0000_0100);
    // wrong type never hits
    apb_access(1'b1, 2'd2, 1'b0, 32'h2000_0240);
    apb_access(1'b1, 2'd2, 1'b1, 32'hFFFF_FFFF);
    for (int i = 0; i < 8; i++) begin
      apb_access(1'b0, 2'(i / 2), i[0], '0);
    end

    // exception trigger hits and misses
    repeat (40) begin
      retire_one(1'b0, 1'b0, rnd(4) != 0, CAUSES[rnd(4)], rnd(2) == 1, 1'b0);
    end

    // debug entry, exit and reentry
    retire_one(1'b1, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);
    retire_one(1'b1, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);
    retire_one(1'b1, 1'b1, 1'b0, 5'd0, 1'b1, 1'b0);
    retire_one(1'b1, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);
    retire_one(1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);

    // debug request while idle and then on a retiring cycle
    @(posedge in_support_if);
    #2;
    debug_req = 1'b1;
    @(posedge in_support_if);
    #2;
    debug_req = 1'b0;
    repeat (4) retire_one(1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);
    retire_one(1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b1);
    repeat (3) retire_one(1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);

    // trap with a granted data request and then a request that follows it
    @(posedge in_support_if);
    #2;
    ctrl   = '{pc_set: 1'b1, pc_is_trap: 1'b1};
    obi[1] = '{req: 1'b1, gnt: 1'b1, gntpar: 1'b0, rvalid: 1'b0};
    @(posedge in_support_if);
    #2;
    ctrl   = '0;
    obi[1] = '{req: 1'b1, gnt: 1'b0, gntpar: 1'b1, rvalid: 1'b1};
    @(posedge in_support_if);
    #2;
    obi[1] = '{req: 1'b1, gnt: 1'b1, gntpar: 1'b0, rvalid: 1'b0};
    retire_one(1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0);
    obi[1] = '{req: 1'b0, gnt: 1'b0, gntpar: 1'b0, rvalid: 1'b1};
    @(posedge in_support_if);
    #2;
    obi[1] = '0;

    // random traffic on both buses
    repeat (OBI_CYCLES) begin
      @(posedge in_support_if);
      #2;
      drive_obi(0, 1'b1);
      drive_obi(1, 1'b1);
    end

    // let every outstanding request finish
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge in_support_if);
      #2;
      if (mdl_cnt[0] == 0 && mdl_cnt[1] == 0 && !mdl_wait[0] && !mdl_wait[1]) begin
        obi[0] = '0;
        obi[1] = '0;
        done   = 1'b1;
      end else if (n >= DRAIN_TIMEOUT) begin
        abort_run("outstanding obi requests did not drain within the timeout");
      end else begin
        drive_obi(0, 1'b0);
        drive_obi(1, 1'b0);
        n++;
      end
    end
    repeat (2) @(posedge in_support_if);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/support_logic.sv */
// observer top for instruction and data obi only; adds no latency to any submodule output
`timescale 1ns/1ps
`default_nettype none

module support_logic (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  sl_pkg::sl_retire_t     retire_i,
  input  sl_pkg::sl_ctrl_t       ctrl_i,
  input  sl_pkg::sl_obi_t        instr_bus_i,
  input  sl_pkg::sl_obi_t        data_bus_i,
  input  logic                   fetch_enable_i,
  input  logic                   debug_req_i,
  input  logic                   instr_integrity_i,
  input  logic                   data_integrity_i,
  input  logic                   data_is_store_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [4:0]             paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output sl_pkg::sl_obi_status_t instr_status_o,
  output sl_pkg::sl_obi_status_t data_status_o,
  output sl_pkg::sl_instr_attr_t instr_resp_attr_o,
  output sl_pkg::sl_data_attr_t  data_resp_attr_o,
  output logic                   etrig_hit_o,
  output sl_pkg::sl_event_t      events_o
);

  // request side attributes, parity error comes from the monitor
  sl_pkg::sl_instr_attr_t instr_attr;
  sl_pkg::sl_data_attr_t  data_attr;

  assign instr_attr = '{integrity: instr_integrity_i, gntpar_err: instr_status_o.gntpar_err};
  assign data_attr  = '{is_store: data_is_store_i, integrity: data_integrity_i,
                        gntpar_err: data_status_o.gntpar_err};

  // ----------------------------------------
  // bus monitors
  // ----------------------------------------
  obi_phase_monitor u_instr_monitor (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .status_o      (instr_status_o)
  );

  obi_phase_monitor u_data_monitor (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .status_o      (data_status_o)
  );

  // ----------------------------------------
  // attribute replay
  // ----------------------------------------
  req_attribute_fifo #(.attr_t(sl_pkg::sl_instr_attr_t)) u_instr_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_attr),
    .resp_attr_o   (instr_resp_attr_o)
  );

  req_attribute_fifo #(.attr_t(sl_pkg::sl_data_attr_t)) u_data_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_attr),
    .resp_attr_o   (data_resp_attr_o)
  );

  // ----------------------------------------
  // triggers and core events
  // ----------------------------------------
  exception_trigger_unit u_etrig (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .retire_i      (retire_i),
    .etrig_hit_o   (etrig_hit_o)
  );

  core_event_tracker u_events (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .retire_i       (retire_i),
    .ctrl_i         (ctrl_i),
    .data_bus_i     (data_bus_i),
    .fetch_enable_i (fetch_enable_i),
    .debug_req_i    (debug_req_i),
    .events_o       (events_o)
  );

endmodule

`default_nettype wire

/* logic/core_event_tracker.sv */
// flags follow retirement order; debug request window covers at most two retirements
`timescale 1ns/1ps
`default_nettype none

module core_event_tracker (
  input  logic               in_support_if,
  input  logic               rst_n_i,
  input  sl_pkg::sl_retire_t retire_i,
  input  sl_pkg::sl_ctrl_t   ctrl_i,
  input  sl_pkg::sl_obi_t    data_bus_i,
  input  logic               fetch_enable_i,
  input  logic               debug_req_i,
  output sl_pkg::sl_event_t  events_o
);

  // fetch_enable was seen since reset
  logic       fetch_enable_q;
  // a debug-mode retirement already happened
  logic       dbg_ins_flag_q;
  // last retirement was an untrapped dret
  logic       dret_q;
  logic       rec_dbg_req_q;
  // retirements left before the debug request record expires
  logic [1:0] dbg_cnt_q;
  // trap taken, no retirement since
  logic       exc_active_q;
  logic       data_gnt_q;
  logic       req_after_exc_q;
  logic       trap_taken;

  assign trap_taken = ctrl_i.pc_set & ctrl_i.pc_is_trap;

  // ----------------------------------------
  // startup and debug entry
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      fetch_enable_q <= 1'b0;
      dbg_ins_flag_q <= 1'b0;
      dret_q         <= 1'b0;
    end else begin
      if (fetch_enable_i) begin
        fetch_enable_q <= 1'b1;
      end
      if (retire_i.valid) begin
        dbg_ins_flag_q <= retire_i.dbg_mode;
        if (retire_i.is_dret && !retire_i.trap) begin
          dret_q <= 1'b1;
        end
      end
      // leaving debug rearms the first instruction flag
      if (dret_q) begin
        dbg_ins_flag_q <= 1'b0;
        dret_q         <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // debug request record
  // ----------------------------------------
  // request on a retiring cycle lasts one more retirement, otherwise two
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      rec_dbg_req_q <= 1'b0;
      dbg_cnt_q     <= '0;
    end else if (retire_i.valid) begin
      if (debug_req_i) begin
        rec_dbg_req_q <= 1'b1;
        dbg_cnt_q     <= 2'd1;
      end else if (dbg_cnt_q != '0) begin
        dbg_cnt_q <= dbg_cnt_q - 1'b1;
      end else begin
        rec_dbg_req_q <= 1'b0;
      end
    end else if (debug_req_i) begin
      rec_dbg_req_q <= 1'b1;
      dbg_cnt_q     <= 2'd2;
    end
  end

  // ----------------------------------------
  // data request after exception
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      exc_active_q    <= 1'b0;
      data_gnt_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
      if (trap_taken) begin
        exc_active_q <= 1'b1;
        if (data_bus_i.req && data_gnt_q) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (retire_i.valid) begin
        exc_active_q    <= 1'b0;
        req_after_exc_q <= 1'b0;
      end else if (exc_active_q && data_gnt_q && data_bus_i.req) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  always_comb begin
    events_o                     = '0;
    events_o.first_fetch         = fetch_enable_i & ~fetch_enable_q;
    events_o.first_debug_ins     = retire_i.valid & retire_i.dbg_mode & ~dbg_ins_flag_q;
    events_o.recorded_dbg_req    = rec_dbg_req_q;
    events_o.req_after_exception = req_after_exc_q;
  end

  // core startup is reported once per reset
  a_first_fetch_once: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    events_o.first_fetch |=> always !events_o.first_fetch);

endmodule

`default_nettype wire

/* logic/exception_trigger_unit.sv */
// apb completer with one wait state per transfer; only exception triggers are decoded
`timescale 1ns/1ps
`default_nettype none

module exception_trigger_unit (
  input  logic               in_support_if,
  input  logic               rst_n_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [4:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  input  sl_pkg::sl_retire_t retire_i,
  output logic               etrig_hit_o
);

  // ----------------------------------------
  // apb access
  // ----------------------------------------
  logic                                    access;
  logic                                    complete;
  logic                                    pready_q;
  logic [1:0]                              trig_idx;
  logic                                    sel_tdata2;
  logic                                    idx_err;
  logic [sl_pkg::NUM_TRIGGERS-1:0][31:0]   tdata1_q;
  logic [sl_pkg::NUM_TRIGGERS-1:0][31:0]   tdata2_q;
  logic [sl_pkg::NUM_TRIGGERS-1:0]         hit;

  assign access     = psel_i & penable_i;
  assign complete   = access & pready_q;
  // bits 1:0 are byte offset and ignored
  assign trig_idx   = paddr_i[4:3];
  assign sel_tdata2 = paddr_i[2];
  assign idx_err    = (int'(trig_idx) >= sl_pkg::NUM_TRIGGERS);

  // ready on the second access cycle, dropped again right after completion
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      pready_q <= 1'b0;
    end else begin
      pready_q <= access & ~pready_q;
    end
  end

  assign pready_o  = pready_q;
  assign pslverr_o = complete & idx_err;

  // register file, writes land at completion
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      tdata1_q <= {sl_pkg::NUM_TRIGGERS{sl_pkg::TDATA1_DEFAULT}};
      tdata2_q <= '0;
    end else if (complete && pwrite_i && !idx_err) begin
      if (sel_tdata2) begin
        tdata2_q[trig_idx] <= pwdata_i;
      end else begin
        tdata1_q[trig_idx] <= pwdata_i;
      end
    end
  end

  // read data only driven on a good read completion
  always_comb begin
    prdata_o = '0;
    if (complete && !pwrite_i && !idx_err) begin
      prdata_o = sel_tdata2 ? tdata2_q[trig_idx] : tdata1_q[trig_idx];
    end
  end

  // ----------------------------------------
  // hit detection
  // ----------------------------------------
  // type 5, cause bit set in tdata2, and enable for the current privilege
  for (genvar t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin : g_trig
    always_comb begin
      hit[t] = retire_i.valid
        && retire_i.exception
        && (tdata1_q[t][sl_pkg::TRIG_TYPE_MSB:sl_pkg::TRIG_TYPE_LSB]
            == sl_pkg::TRIG_TYPE_ETRIGGER)
        && tdata2_q[t][retire_i.exception_cause]
        && ((retire_i.is_mmode && tdata1_q[t][sl_pkg::ET_M_BIT])
            || (retire_i.is_umode && tdata1_q[t][sl_pkg::ET_U_BIT]));
    end
  end

  assign etrig_hit_o = |hit;

  // host must hold psel and penable until ready
  a_pready_in_access: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    pready_o |-> access);

endmodule

`default_nettype wire

/* logic/req_attribute_fifo.sv */
// depth must be a power of two; output reads zero on any cycle without rvalid
`timescale 1ns/1ps
`default_nettype none

module req_attribute_fifo #(
  parameter type attr_t = logic
) (
  input  logic            in_support_if,
  input  logic            rst_n_i,
  input  sl_pkg::sl_obi_t bus_i,
  input  attr_t           attr_i,
  output attr_t           resp_attr_o
);

  // ----------------------------------------
  // storage
  // ----------------------------------------
  attr_t                        mem_q [sl_pkg::OBI_MAX_OUTSTANDING];
  logic [sl_pkg::OBI_PTR_W-1:0] wr_ptr_q;
  logic [sl_pkg::OBI_PTR_W-1:0] rd_ptr_q;
  // entries held, needs one more bit than the pointers
  logic [sl_pkg::CNT_W-1:0]     fill_q;
  logic                         push;
  logic                         pop;
  logic                         full;

  // push on address phase acceptance, pop on the response
  assign push = bus_i.req & bus_i.gnt;
  assign pop  = bus_i.rvalid;
  assign full = (fill_q == sl_pkg::CNT_W'(sl_pkg::OBI_MAX_OUTSTANDING));

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // ----------------------------------------
  // response side
  // ----------------------------------------
  // oldest entry belongs to the response on the bus this cycle
  always_comb begin
    if (pop) begin
      resp_attr_o = mem_q[rd_ptr_q];
    end else begin
      resp_attr_o = '0;
    end
  end

  // a pop in the same cycle frees the slot being written
  a_no_push_full: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    (push && !pop) |-> !full);

  // responses only come for stored requests
  a_no_pop_empty: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    pop |-> fill_q != '0);

endmodule

`default_nettype wire

/* logic/obi_phase_monitor.sv */
// observes one obi bus only; assumes in-order responses, never earlier than the cycle after grant
`timescale 1ns/1ps
`default_nettype none

module obi_phase_monitor (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  sl_pkg::sl_obi_t        bus_i,
  output sl_pkg::sl_obi_status_t status_o
);

  // address phase accepted this cycle
  logic                     accept;
  // req was waiting for gnt last cycle
  logic                     req_wait_q;
  // accepted but unanswered requests
  logic [sl_pkg::CNT_W-1:0] cnt_q;
  // parity error seen earlier in the current address phase
  logic                     gntpar_err_q;
  logic                     gntpar_err;

  assign accept = bus_i.req & bus_i.gnt;

  // gntpar must be the inverse of gnt, a mismatch sticks until the phase ends
  assign gntpar_err = bus_i.req & ((bus_i.gnt == bus_i.gntpar) | gntpar_err_q);

  // ----------------------------------------
  // phase state
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      req_wait_q   <= 1'b0;
      gntpar_err_q <= 1'b0;
      cnt_q        <= '0;
    end else begin
      req_wait_q <= bus_i.req & ~bus_i.gnt;
      // only carry the error across waiting cycles
      if (bus_i.req && !bus_i.gnt) begin
        gntpar_err_q <= gntpar_err;
      end else begin
        gntpar_err_q <= 1'b0;
      end
      // accept and rvalid together leave the count unchanged
      case ({accept, bus_i.rvalid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_comb begin
    status_o               = '0;
    status_o.addr_ph_cont  = bus_i.req & req_wait_q;
    status_o.resp_ph_cont  = bus_i.rvalid & (cnt_q != '0);
    status_o.v_addr_ph_cnt = cnt_q;
    status_o.gntpar_err    = gntpar_err;
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // the core never issues more than the fifo depth
  a_cnt_limit: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    cnt_q <= sl_pkg::CNT_W'(sl_pkg::OBI_MAX_OUTSTANDING));

  // a response needs an earlier accepted request
  a_no_orphan_rvalid: assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    bus_i.rvalid |-> cnt_q != '0);

endmodule

`default_nettype wire

/* logic/sl_pkg.sv */
// shared constants and bundles for a two-bus observer; depth and pointer width must stay consistent
`default_nettype none

package sl_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  // implemented trigger slots
  localparam int NUM_TRIGGERS = 4;
  // fifo depth, also the outstanding limit per bus
  localparam int OBI_MAX_OUTSTANDING = 4;
  // pointer width for a power-of-two depth
  localparam int OBI_PTR_W = $clog2(OBI_MAX_OUTSTANDING);
  // outstanding count width, must hold OBI_MAX_OUTSTANDING itself
  localparam int CNT_W = 3;

  // ----------------------------------------
  // trigger fields
  // ----------------------------------------
  localparam logic [31:0] TDATA1_DEFAULT = 32'hF800_0000;
  localparam int TRIG_TYPE_LSB = 28;
  localparam int TRIG_TYPE_MSB = 31;
  localparam logic [3:0] TRIG_TYPE_ETRIGGER = 4'd5;
  // mode enables inside tdata1 for exception triggers
  localparam int ET_M_BIT = 9;
  localparam int ET_U_BIT = 6;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  // one retirement as seen on the trace port
  typedef struct packed {
    logic       valid;
    logic       dbg_mode;
    logic       is_dret;
    logic       trap;
    logic       exception;
    logic [4:0] exception_cause;
    logic       is_mmode;
    logic       is_umode;
  } sl_retire_t;

  // controller pc update, pc_is_trap covers exception and bus error muxes
  typedef struct packed {
    logic pc_set;
    logic pc_is_trap;
  } sl_ctrl_t;

  // handshake of one observed obi bus
  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
  } sl_obi_t;

  // per-bus monitor result
  typedef struct packed {
    logic             addr_ph_cont;
    logic             resp_ph_cont;
    logic [CNT_W-1:0] v_addr_ph_cnt;
    logic             gntpar_err;
  } sl_obi_status_t;

  // attributes replayed with a data response
  typedef struct packed {
    logic is_store;
    logic integrity;
    logic gntpar_err;
  } sl_data_attr_t;

  // attributes replayed with an instruction response
  typedef struct packed {
    logic integrity;
    logic gntpar_err;
  } sl_instr_attr_t;

  // core event flags
  typedef struct packed {
    logic first_fetch;
    logic first_debug_ins;
    logic recorded_dbg_req;
    logic req_after_exception;
  } sl_event_t;

endpackage

`default_nettype wire
